// File: logic/obj_consts.svh
`ifndef OBJ_CONSTS_SVH
`define OBJ_CONSTS_SVH

// Geometry of the sprite line unit

// Visible columns on one scanline
`define OBJ_LINE_WIDTH 240

// Pixels carried by one sprite sliver
`define OBJ_SLIVER_WIDTH 8

// Bits needed to index a column, including the hidden columns 240 to 255
`define OBJ_COL_BITS 8

// Width of one palette index; index 0 is transparent
`define OBJ_INDEX_BITS 4

// Width of a palette number
`define OBJ_PALETTE_BITS 3

`endif

// File: logic/obj_pkg.sv
`include "obj_consts.svh"

package obj_pkg;

    // One sprite's pixels on one line, as handed over by sprite evaluation
    typedef struct packed {
        logic [`OBJ_COL_BITS-1:0]                             x;  // First column
        logic [`OBJ_PALETTE_BITS-1:0]                         palette;
        logic                                                 behind_bg;
        logic [`OBJ_SLIVER_WIDTH-1:0][`OBJ_INDEX_BITS-1:0]    pixels;  // Pixel 0 leftmost
    } obj_sliver_t;

    // Sprite pixel held in a row buffer column, all zero when the column is empty
    typedef struct packed {
        logic                          opaque;
        logic                          behind_bg;
        logic [`OBJ_PALETTE_BITS-1:0]  palette;
        logic [`OBJ_INDEX_BITS-1:0]    index;
    } obj_pixel_t;

    // Background pixel from the tile pipeline
    typedef struct packed {
        logic [`OBJ_PALETTE_BITS-1:0]  palette;
        logic [`OBJ_INDEX_BITS-1:0]    index;  // Zero lets a behind_bg sprite through
    } bg_pixel_t;

    // Final colour, ready for the palette RAM lookup
    typedef struct packed {
        logic                          bank;  // Set selects the sprite palettes
        logic [`OBJ_PALETTE_BITS-1:0]  palette;
        logic [`OBJ_INDEX_BITS-1:0]    index;
    } color_t;

endpackage

// File: logic/obj_pixel_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "obj_consts.svh"

module obj_pixel_writer
    import obj_pkg::*;
(
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     sliver_valid,
    input  obj_sliver_t              sliver,
    output logic                     busy,
    output logic                     wr_en,
    output logic [`OBJ_COL_BITS-1:0] wr_col,
    output obj_pixel_t               wr_pixel
);

    localparam int SLOT_BITS = $clog2(`OBJ_SLIVER_WIDTH);
    localparam logic [SLOT_BITS-1:0] LAST_SLOT = SLOT_BITS'(`OBJ_SLIVER_WIDTH - 1);
    localparam logic [`OBJ_COL_BITS:0] LINE_END = (`OBJ_COL_BITS + 1)'(`OBJ_LINE_WIDTH);

    obj_sliver_t                 sliver_q;
    logic [SLOT_BITS-1:0]        slot;
    logic [`OBJ_COL_BITS:0]      col_sum;  // Extra bit keeps x near 255 from wrapping
    logic [`OBJ_INDEX_BITS-1:0]  cur_index;

    // Slot counter runs for one sliver width after each strobe
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            slot <= '0;
        end else if (sliver_valid) begin
            busy <= 1'b1;
            slot <= '0;
        end else if (busy) begin
            slot <= slot + 1'b1;
            if (slot == LAST_SLOT)
                busy <= 1'b0;  // Last pixel goes out this cycle
        end
    end

    // The pixel field shifts right so the current pixel always sits in slot 0
    always_ff @(posedge clock) begin
        if (sliver_valid) begin
            sliver_q <= sliver;
        end else if (busy) begin
            sliver_q.pixels <= {{`OBJ_INDEX_BITS{1'b0}},
                                sliver_q.pixels[`OBJ_SLIVER_WIDTH-1:1]};
        end
    end

    assign cur_index = sliver_q.pixels[0];
    assign col_sum   = {1'b0, sliver_q.x} + {{(`OBJ_COL_BITS + 1 - SLOT_BITS){1'b0}}, slot};

    // Transparent and off-line pixels still burn their slot but never write
    always_comb begin
        wr_en  = busy && (cur_index != '0) && (col_sum < LINE_END);
        wr_col = col_sum[`OBJ_COL_BITS-1:0];

        wr_pixel.opaque    = 1'b1;
        wr_pixel.behind_bg = sliver_q.behind_bg;
        wr_pixel.palette   = sliver_q.palette;
        wr_pixel.index     = cur_index;
    end

    // Sprite evaluation has to wait for busy to drop before the next sliver
    a_no_strobe_while_busy: assert property (
        @(posedge clock) disable iff (!rst_n)
        sliver_valid |-> !busy
    ) else $error("sliver strobed while the writer is still busy");

    // A sliver occupies the write port for exactly one sliver width of cycles
    a_busy_length: assert property (
        @(posedge clock) disable iff (!rst_n)
        sliver_valid |=> busy [*`OBJ_SLIVER_WIDTH] ##1 !busy
    ) else $error("writer busy window has the wrong length");

endmodule

`default_nettype wire

// File: logic/obj_row_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "obj_consts.svh"

module obj_row_buffer
    import obj_pkg::*;
#(
    parameter int WIDTH = `OBJ_LINE_WIDTH
) (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     en,
    input  logic                     clear,
    input  logic [`OBJ_COL_BITS-1:0] wcol,
    input  obj_pixel_t               wdata,
    input  logic [`OBJ_COL_BITS-1:0] rcol,
    output obj_pixel_t               rdata
);

    localparam int DEPTH = 2 ** `OBJ_COL_BITS;

    logic [DEPTH-1:0] col_hot;
    obj_pixel_t       cols [WIDTH];

    // Column decoder covers the full index range so off-line columns hit nothing stored
    always_comb begin
        col_hot       = '0;
        col_hot[wcol] = 1'b1;
    end

    generate
        for (genvar i = 0; i < WIDTH; i++) begin : g_col
            obj_pixel_t col_q;

            // The first opaque pixel into a column blocks every later one
            always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                    col_q <= '0;
                end else if (en && clear) begin
                    col_q <= '0;
                end else if (en && col_hot[i] && !col_q.opaque) begin
                    col_q <= wdata;
                end
            end

            assign cols[i] = col_q;
        end
    endgenerate

    // Columns past the visible line read as empty
    always_comb begin
        rdata = '0;
        if (int'(rcol) < WIDTH)
            rdata = cols[rcol];
    end

    // Clear must leave the bank empty for the whole following cycle
    a_clear_empties: assert property (
        @(posedge clock) disable iff (!rst_n)
        (en && clear) |=> (cols[0] == '0)
    ) else $error("column 0 still holds a pixel after clear");

endmodule

`default_nettype wire

// File: logic/obj_row_double_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "obj_consts.svh"

module obj_row_double_buffer
    import obj_pkg::*;
(
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic [`OBJ_COL_BITS-1:0] row,
    input  logic                     clear,
    input  logic                     we,
    input  logic [`OBJ_COL_BITS-1:0] wcol,
    input  obj_pixel_t               wdata,
    input  logic [`OBJ_COL_BITS-1:0] rcol,
    output obj_pixel_t               rdata
);

    obj_pixel_t rdata_even;
    obj_pixel_t rdata_odd;
    logic       access;

    assign access = clear | we;

    // Odd rows are built in the odd bank while the even bank is on screen
    obj_row_buffer #(.WIDTH(`OBJ_LINE_WIDTH)) u_even (
        .clock, .rst_n,
        .en(access & ~row[0]), .clear,
        .wcol, .wdata,
        .rcol, .rdata(rdata_even)
    );

    obj_row_buffer #(.WIDTH(`OBJ_LINE_WIDTH)) u_odd (
        .clock, .rst_n,
        .en(access & row[0]), .clear,
        .wcol, .wdata,
        .rcol, .rdata(rdata_odd)
    );

    assign rdata = row[0] ? rdata_even : rdata_odd;  // Read the bank filled last line

    a_clear_not_during_write: assert property (
        @(posedge clock) disable iff (!rst_n)
        !(clear && we)
    ) else $error("clear pulsed while a sliver is being written");

    // Row only moves between slivers, so a write never lands in the shown bank
    a_row_stable_on_write: assert property (
        @(posedge clock) disable iff (!rst_n)
        we |-> $stable(row)
    ) else $error("row changed while the writer was busy");

endmodule

`default_nettype wire

// File: logic/obj_line_mixer.sv
`timescale 1ns/1ps
`default_nettype none

`include "obj_consts.svh"

module obj_line_mixer
    import obj_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  logic       pixel_valid,
    input  obj_pixel_t spr,
    input  bg_pixel_t  bg,
    output logic       out_valid,
    output color_t     out_pixel
);

    logic   show_sprite;
    color_t mix;

    // A behind_bg sprite only shows through transparent background
    assign show_sprite = spr.opaque && (!spr.behind_bg || (bg.index == '0));

    always_comb begin
        if (show_sprite) begin
            mix.bank    = 1'b1;
            mix.palette = spr.palette;
            mix.index   = spr.index;
        end else begin
            mix.bank    = 1'b0;
            mix.palette = bg.palette;
            mix.index   = bg.index;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= pixel_valid;
    end

    // Colour is registered every cycle and qualified by out_valid
    always_ff @(posedge clock) begin
        out_pixel <= mix;
    end

endmodule

`default_nettype wire

// File: logic/obj_line_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "obj_consts.svh"

module obj_line_unit
    import obj_pkg::*;
(
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic [`OBJ_COL_BITS-1:0] row,  // Scanline being built, shown one row later
    input  logic                     clear,
    input  logic                     sliver_valid,
    input  obj_sliver_t              sliver,
    output logic                     busy,
    input  logic [`OBJ_COL_BITS-1:0] rcol,
    input  bg_pixel_t                bg,
    input  logic                     pixel_valid,
    output logic                     out_valid,
    output color_t                   out_pixel
);

    logic                     wr_en;
    logic [`OBJ_COL_BITS-1:0] wr_col;
    obj_pixel_t               wr_pixel;
    obj_pixel_t               rd_pixel;

    obj_pixel_writer u_writer (
        .clock, .rst_n,
        .sliver_valid, .sliver,
        .busy,
        .wr_en, .wr_col, .wr_pixel
    );

    obj_row_double_buffer u_rows (
        .clock, .rst_n,
        .row, .clear,
        .we(wr_en), .wcol(wr_col), .wdata(wr_pixel),
        .rcol, .rdata(rd_pixel)
    );

    // Read path is combinational up to the mixer register
    obj_line_mixer u_mixer (
        .clock, .rst_n,
        .pixel_valid,
        .spr(rd_pixel), .bg,
        .out_valid, .out_pixel
    );

endmodule

`default_nettype wire

// File: sim/tb_obj_checks.svh
`ifndef TB_OBJ_CHECKS_SVH
`define TB_OBJ_CHECKS_SVH

int pixel_errors   = 0;
int valid_errors   = 0;
int clip_errors    = 0;
int busy_errors    = 0;
int timeout_errors = 0;

a_out_valid_follows: assert property (
    @(posedge clock) disable iff (!rst_n)
    out_valid == exp_valid_q
) else begin
    valid_errors++;
    $display("error at %0t: out_valid is %b, expected %b",
             $time, $sampled(out_valid), $sampled(exp_valid_q));
end

// Colour seen one cycle after the column was presented
a_out_pixel_matches: assert property (
    @(posedge clock) disable iff (!rst_n)
    out_valid |-> (out_pixel == exp_pixel_q)
) else begin
    pixel_errors++;
    $display("error at %0t: column %0d shows %h, expected %h",
             $time, $sampled(rcol_q), $sampled(out_pixel), $sampled(exp_pixel_q));
end

a_clip_shows_background: assert property (
    @(posedge clock) disable iff (!rst_n)
    (out_valid && rcol_q >= 8'(`OBJ_LINE_WIDTH)) |-> !out_pixel.bank
) else begin
    clip_errors++;
    $display("error at %0t: sprite colour at hidden column %0d", $time, $sampled(rcol_q));
end

a_busy_after_strobe: assert property (
    @(posedge clock) disable iff (!rst_n)
    sliver_valid |=> busy
) else begin
    busy_errors++;
    $display("error at %0t: busy stayed low after a sliver strobe", $time);
end

task automatic report_result();
    int total;
    total = pixel_errors + valid_errors + clip_errors + busy_errors + timeout_errors;
    $display("Checked %0d pixels: %0d pixel, %0d valid, %0d clip, %0d busy, %0d timeout errors",
             pixels_checked, pixel_errors, valid_errors, clip_errors, busy_errors,
             timeout_errors);
    if (total == 0) begin
        $display("Result: PASSED");
    end else begin
        $display("Result: FAILED");
    end
endtask

`endif

// File: sim/tb_obj_line_unit.sv
`timescale 1ns/1ps

`include "obj_consts.svh"

module tb_obj_line_unit
    import obj_pkg::*;
();

    localparam int          CLK_PERIOD   = 40;
    localparam int          DRIVE_DELAY  = 2;
    localparam int          RESET_CYCLES = 16;
    localparam int          NUM_LINES    = 10;
    localparam int          BUSY_TIMEOUT = 20;  // Cycles allowed for one sliver
    localparam logic [31:0] SEED         = 32'hbcd4deda;

    logic                     clock;
    logic                     rst_n;
    logic [`OBJ_COL_BITS-1:0] row;
    logic                     clear;
    logic                     sliver_valid;
    obj_sliver_t              sliver;
    logic                     busy;
    logic [`OBJ_COL_BITS-1:0] rcol;
    bg_pixel_t                bg;
    logic                     pixel_valid;
    logic                     out_valid;
    color_t                   out_pixel;

    // Shadow copy of both banks, indexed by row parity
    obj_pixel_t               shadow [2][2**`OBJ_COL_BITS];
    logic [31:0]              rng_state;
    logic                     exp_valid_q;
    color_t                   exp_pixel_q;
    logic [`OBJ_COL_BITS-1:0] rcol_q;
    int                       pixels_checked;

    obj_line_unit u_obj_line_unit (
        .clock, .rst_n, .row, .clear, .sliver_valid, .sliver, .busy,
        .rcol, .bg, .pixel_valid, .out_valid, .out_pixel
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    // A sprite wins unless it hides behind a background pixel that is not transparent
    function automatic color_t expected_color(input obj_pixel_t spr, input bg_pixel_t b);
        color_t c;
        logic   bg_clear;
        bg_clear  = (b.index == 4'd0);
        c.bank    = 1'b0;
        c.palette = b.palette;
        c.index   = b.index;
        if (spr.opaque && (bg_clear || !spr.behind_bg)) begin
            c.bank    = 1'b1;
            c.palette = spr.palette;
            c.index   = spr.index;
        end
        return c;
    endfunction

    // Expected output one cycle behind the display inputs
    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            exp_valid_q    <= 1'b0;
            exp_pixel_q    <= '0;
            rcol_q         <= '0;
            pixels_checked <= 0;
        end else begin
            exp_valid_q <= pixel_valid;
            exp_pixel_q <= expected_color(shadow[!row[0]][rcol], bg);
            rcol_q      <= rcol;
            if (out_valid)
                pixels_checked <= pixels_checked + 1;
        end
    end

    `include "tb_obj_checks.svh"

    task automatic next_cycle();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    function automatic bg_pixel_t random_bg();
        logic [31:0] r;
        bg_pixel_t   b;
        r         = next_random();
        b.palette = r[2:0];
        b.index   = (r[5:4] == 2'b00) ? 4'd0 : r[11:8];  // Transparent about a quarter of the time
        return b;
    endfunction

    task automatic show_random_pixel();
        logic [31:0] r;
        r           = next_random();
        rcol        = r[7:0];
        bg          = random_bg();
        pixel_valid = 1'b1;
    endtask

    function automatic obj_sliver_t make_sliver(input logic [7:0] x, input logic [2:0] palette,
                                                input logic behind, input logic [31:0] pixels);
        obj_sliver_t s;
        s.x         = x;
        s.palette   = palette;
        s.behind_bg = behind;
        s.pixels    = pixels;
        return s;
    endfunction

    function automatic obj_sliver_t random_sliver();
        logic [31:0] r;
        r = next_random();
        return make_sliver(r[7:0], r[10:8], r[11] & r[12], next_random() & next_random());
    endfunction

    task automatic clear_model_bank(input logic bank);
        for (int c = 0; c < 2**`OBJ_COL_BITS; c++)
            shadow[bank][c[7:0]] = '0;
    endtask

    task automatic store_in_model(input obj_sliver_t s);
        logic       bank;
        int         col;
        obj_pixel_t p;
        bank = row[0];
        for (int k = 0; k < `OBJ_SLIVER_WIDTH; k++) begin
            col         = int'(s.x) + k;
            p.opaque    = 1'b1;
            p.behind_bg = s.behind_bg;
            p.palette   = s.palette;
            p.index     = s.pixels[k[2:0]];
            if (p.index != 4'd0 && col < `OBJ_LINE_WIDTH && !shadow[bank][col[7:0]].opaque)
                shadow[bank][col[7:0]] = p;
        end
    endtask

    // The display keeps running while the sliver goes into the other bank
    task automatic send_sliver(input obj_sliver_t s, output bit ok);
        int waited;
        ok           = 1'b1;
        waited       = 0;
        sliver       = s;
        sliver_valid = 1'b1;
        store_in_model(s);
        show_random_pixel();
        next_cycle();
        sliver_valid = 1'b0;
        while (busy) begin
            if (waited >= BUSY_TIMEOUT) begin
                timeout_errors++;
                $display("Writer stayed busy for more than %0d cycles after a sliver", waited);
                ok = 1'b0;
                return;
            end
            show_random_pixel();
            next_cycle();
            waited++;
        end
    endtask

    task automatic run_line(input int line, output bit ok);
        obj_sliver_t slivers[$];
        int          count;
        ok    = 1'b1;
        clear = 1'b1;
        clear_model_bank(row[0]);
        show_random_pixel();
        next_cycle();
        clear = 1'b0;
        case (line % 3)
            0: begin
                slivers.push_back(make_sliver(8'd236, 3'd5, 1'b0, 32'h89ab_cdef));  // Clipped
                slivers.push_back(make_sliver(8'd40, 3'd2, 1'b0, 32'h1111_1111));
                slivers.push_back(make_sliver(8'd44, 3'd6, 1'b0, 32'h3333_3333));
                slivers.push_back(make_sliver(8'd60, 3'd1, 1'b0, 32'h5050_5050));
                slivers.push_back(make_sliver(8'd60, 3'd4, 1'b0, 32'h0707_0707));  // Fills holes
                slivers.push_back(make_sliver(8'd100, 3'd3, 1'b1, 32'h9999_9999));
            end
            1: begin
                count = 1 + int'(next_random() % 32'd6);
                repeat (count) slivers.push_back(random_sliver());
            end
            default: ;  // An empty line shows whether the clear worked
        endcase
        foreach (slivers[i]) begin
            send_sliver(slivers[i], ok);
            if (!ok)
                return;
        end
        row = row + 8'd1;
        for (int c = 0; c < 2**`OBJ_COL_BITS; c++) begin
            rcol        = c[7:0];
            bg          = random_bg();
            pixel_valid = 1'b1;
            next_cycle();
        end
        pixel_valid = 1'b0;
    endtask

    initial begin
        bit ok;
        rst_n        = 1'b0;
        row          = '0;
        clear        = 1'b0;
        sliver_valid = 1'b0;
        sliver       = '0;
        rcol         = '0;
        bg           = '0;
        pixel_valid  = 1'b0;
        rng_state    = SEED;
        clear_model_bank(1'b0);
        clear_model_bank(1'b1);
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        ok    = 1'b1;
        for (int line = 0; line < NUM_LINES && ok; line++)
            run_line(line, ok);
        pixel_valid = 1'b0;
        next_cycle();
        next_cycle();
        report_result();
        $finish;
    end

endmodule

// File: flist.f
+incdir+logic
+incdir+sim
logic/obj_pkg.sv
logic/obj_pixel_writer.sv
logic/obj_row_buffer.sv
logic/obj_row_double_buffer.sv
logic/obj_line_mixer.sv
logic/obj_line_unit.sv
sim/tb_obj_line_unit.sv

// File: Makefile
# Verilator build and run of the sprite line unit testbench

VERILATOR ?= verilator
TOP       ?= tb_obj_line_unit
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Result: PASSED

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard logic/*.svh sim/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(BIN)

$(BIN): $(FLIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qx '$(PASS_TEXT)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

check:
	@test -f $(LOG) || { echo "No log file $(LOG), run the simulation first"; exit 1; }
	@grep -qx '$(PASS_TEXT)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Log $(LOG) reports a pass"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
